// ==== hdl/core_pkg.sv ====
package core_pkg;

	////////////////////
	// Widths
	////////////////////
	typedef logic [31:0] word_t;       // Register values, operands, memory data
	typedef logic [11:0] pc_t;         // Instruction byte address
	typedef logic [4:0]  reg_addr_t;   // Register index
	typedef logic [9:0]  dm_addr_t;    // Data memory word address
	typedef logic [9:0]  im_addr_t;    // Instruction memory word address

	localparam int IMEM_WORDS = 1024;
	localparam int DMEM_WORDS = 1024;

	localparam word_t NOP_INST = 32'h0000_0013;  // addi x0, x0, 0

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP_LOAD  = 7'b0000011,
		OP_IMM   = 7'b0010011,
		OP_STORE = 7'b0100011,
		OP_REG   = 7'b0110011,
		OP_LUI   = 7'b0110111
	} opcode_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B    // LUI
	} alu_op_t;

	typedef enum logic {
		WB_ALU,
		WB_MEM
	} wb_sel_t;

	// Control word carried down the pipe
	typedef struct packed {
		alu_op_t alu_op;
		logic    use_imm;     // Operand B from immediate
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		wb_sel_t wb_sel;
	} ctrl_t;

	// Bubble, nothing written anywhere
	localparam ctrl_t CTRL_NOP = '{
		alu_op:    ALU_ADD,
		use_imm:   1'b0,
		reg_write: 1'b0,
		mem_read:  1'b0,
		mem_write: 1'b0,
		wb_sel:    WB_ALU
	};

endpackage

// ==== hdl/core_if.sv ====
`timescale 1ns/10ps

interface forward_if;
	import core_pkg::*;

	// EXE stage
	reg_addr_t exe_rd;
	logic      exe_reg_write;
	word_t     exe_result;     // ALU output
	logic      exe_mem_read;   // Load in EXE, result not ready yet

	// MEM stage
	reg_addr_t mem_rd;
	logic      mem_reg_write;
	word_t     mem_result;     // Load data or ALU result

	// WB stage
	reg_addr_t wb_rd;
	logic      wb_reg_write;
	word_t     wb_result;      // Final write data

	modport producer (
		output exe_rd, exe_reg_write, exe_result, exe_mem_read,
		output mem_rd, mem_reg_write, mem_result,
		output wb_rd, wb_reg_write, wb_result
	);

	modport consumer (
		input exe_rd, exe_reg_write, exe_result, exe_mem_read,
		input mem_rd, mem_reg_write, mem_result,
		input wb_rd, wb_reg_write, wb_result
	);

endinterface

// ==== hdl/instmem.sv ====
`timescale 1ns/10ps

module instmem #(
	parameter int IMEM_WORDS = core_pkg::IMEM_WORDS
) (
	input  logic               clk,
	input  core_pkg::pc_t      addr,        // Byte address from PC
	output core_pkg::word_t    inst,
	input  logic               prog_write,  // Program load strobe
	input  core_pkg::im_addr_t prog_addr,
	input  core_pkg::word_t    prog_in
);
	import core_pkg::*;

	word_t mem [IMEM_WORDS];

	// Empty memory runs NOPs
	initial begin
		for (int i = 0; i < IMEM_WORDS; i++) begin
			mem[i] = NOP_INST;
		end
	end

	always_ff @(posedge clk) begin
		if (prog_write) begin
			mem[prog_addr] <= prog_in;
		end
	end

	assign inst = mem[addr[11:2]];   // Async read, low bits dropped

endmodule

// ==== hdl/decoder.sv ====
`timescale 1ns/10ps

module decoder (
	input  core_pkg::word_t     inst,
	output core_pkg::ctrl_t     ctrl,
	output core_pkg::reg_addr_t rs1,
	output core_pkg::reg_addr_t rs2,
	output core_pkg::reg_addr_t rd,
	output logic                uses_rs2,
	output core_pkg::word_t     imm
);
	import core_pkg::*;

	opcode_t    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       legal;
	logic       uses_rs1;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_u;

	// Shared by register and immediate forms
	function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic sub);
		case (f3)
			3'b000:  alu_sel = sub ? ALU_SUB : ALU_ADD;
			3'b001:  alu_sel = ALU_SLL;
			3'b010:  alu_sel = ALU_SLT;
			3'b100:  alu_sel = ALU_XOR;
			3'b101:  alu_sel = ALU_SRL;
			3'b110:  alu_sel = ALU_OR;
			default: alu_sel = ALU_AND;
		endcase
	endfunction

	assign opcode = opcode_t'(inst[6:0]);
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_u = {inst[31:12], 12'b0};

	always_comb begin
		ctrl     = CTRL_NOP;
		imm      = '0;
		legal    = 1'b0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (opcode)
			OP_IMM: begin
				// No SLTIU, no SRAI
				legal          = (funct3 != 3'b011) && (funct3[1:0] != 2'b01 || funct7 == 7'h00);
				ctrl.alu_op    = alu_sel(funct3, 1'b0);
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				uses_rs1       = 1'b1;
				imm            = imm_i;
			end
			OP_REG: begin
				// funct7 0x20 only for SUB
				legal = (funct3 != 3'b011)
					&& (funct7 == 7'h00 || (funct7 == 7'h20 && funct3 == 3'b000));
				ctrl.alu_op    = alu_sel(funct3, funct7[5]);
				ctrl.reg_write = 1'b1;
				uses_rs1       = 1'b1;
				uses_rs2       = 1'b1;
			end
			OP_LUI: begin
				legal          = 1'b1;
				ctrl.alu_op    = ALU_PASS_B;
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				imm            = imm_u;
			end
			OP_LOAD: begin
				legal          = (funct3 == 3'b010);   // LW only
				ctrl.use_imm   = 1'b1;
				ctrl.reg_write = 1'b1;
				ctrl.mem_read  = 1'b1;
				ctrl.wb_sel    = WB_MEM;
				uses_rs1       = 1'b1;
				imm            = imm_i;
			end
			OP_STORE: begin
				legal          = (funct3 == 3'b010);   // SW only
				ctrl.use_imm   = 1'b1;
				ctrl.mem_write = 1'b1;
				uses_rs1       = 1'b1;
				uses_rs2       = 1'b1;                 // Store data
				imm            = imm_s;
			end
			default: legal = 1'b0;
		endcase
		if (!legal) begin
			ctrl     = CTRL_NOP;   // Illegal word becomes a bubble
			uses_rs1 = 1'b0;
			uses_rs2 = 1'b0;
		end
	end

	// Unused rs1 reads x0 so it never matches a hazard
	assign rs1 = uses_rs1 ? inst[19:15] : '0;
	assign rs2 = inst[24:20];
	assign rd  = inst[11:7];

endmodule

// ==== hdl/regfile.sv ====
`timescale 1ns/10ps

module regfile (
	input  logic                clk,
	input  logic                reset,
	input  logic                wr_en,
	input  core_pkg::reg_addr_t dest_addr,
	input  core_pkg::word_t     wr_data,
	input  core_pkg::reg_addr_t src1_addr,
	input  core_pkg::reg_addr_t src2_addr,
	output core_pkg::word_t     src1_out,
	output core_pkg::word_t     src2_out
);
	import core_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && dest_addr != '0) begin   // x0 stays zero
			regs[dest_addr] <= wr_data;
		end
	end

	// Async reads, same-cycle WB write covered by forwarding
	assign src1_out = regs[src1_addr];
	assign src2_out = regs[src2_addr];

endmodule

// ==== hdl/operand_forward.sv ====
`timescale 1ns/10ps

module operand_forward (
	forward_if.consumer         fwd,
	input  core_pkg::reg_addr_t rs1,
	input  core_pkg::reg_addr_t rs2,
	input  logic                uses_rs2,
	input  core_pkg::word_t     rf_a,
	input  core_pkg::word_t     rf_b,
	output core_pkg::word_t     op_a,
	output core_pkg::word_t     op_b,
	output logic                stall
);
	import core_pkg::*;

	logic exe_hit_a;
	logic exe_hit_b;
	logic mem_hit_a;
	logic mem_hit_b;
	logic wb_hit_a;
	logic wb_hit_b;

	// Producer writes the nonzero source register
	function automatic logic hit(input reg_addr_t rd, input logic we, input reg_addr_t src);
		hit = we && (rd == src) && (src != '0);
	endfunction

	assign exe_hit_a = hit(fwd.exe_rd, fwd.exe_reg_write, rs1);
	assign exe_hit_b = hit(fwd.exe_rd, fwd.exe_reg_write, rs2);
	assign mem_hit_a = hit(fwd.mem_rd, fwd.mem_reg_write, rs1);
	assign mem_hit_b = hit(fwd.mem_rd, fwd.mem_reg_write, rs2);
	assign wb_hit_a  = hit(fwd.wb_rd, fwd.wb_reg_write, rs1);
	assign wb_hit_b  = hit(fwd.wb_rd, fwd.wb_reg_write, rs2);

	// Youngest producer first
	assign op_a = exe_hit_a ? fwd.exe_result :
	              mem_hit_a ? fwd.mem_result :
	              wb_hit_a  ? fwd.wb_result  : rf_a;
	assign op_b = exe_hit_b ? fwd.exe_result :
	              mem_hit_b ? fwd.mem_result :
	              wb_hit_b  ? fwd.wb_result  : rf_b;

	// Load data only exists from MEM on, so hold decode one cycle
	assign stall = fwd.exe_mem_read && (exe_hit_a || (uses_rs2 && exe_hit_b));

endmodule

// ==== hdl/alu.sv ====
`timescale 1ns/10ps

module alu (
	input  core_pkg::word_t   op_a,
	input  core_pkg::word_t   op_b,
	input  core_pkg::alu_op_t alu_op,
	output core_pkg::word_t   res
);
	import core_pkg::*;

	logic [4:0] shamt;

	assign shamt = op_b[4:0];   // Shift amount masked to 5 bits

	always_comb begin
		case (alu_op)
			ALU_ADD:    res = op_a + op_b;   // Also load/store address
			ALU_SUB:    res = op_a - op_b;
			ALU_AND:    res = op_a & op_b;
			ALU_OR:     res = op_a | op_b;
			ALU_XOR:    res = op_a ^ op_b;
			ALU_SLT:    res = {31'b0, $signed(op_a) < $signed(op_b)};
			ALU_SLL:    res = op_a << shamt;
			ALU_SRL:    res = op_a >> shamt;    // Logical
			ALU_PASS_B: res = op_b;             // LUI immediate
			default:    res = '0;
		endcase
	end

endmodule

// ==== hdl/datamem.sv ====
`timescale 1ns/10ps

module datamem #(
	parameter int DMEM_WORDS = core_pkg::DMEM_WORDS
) (
	input  logic               clk,
	input  logic               dm_write,     // Core word write
	input  core_pkg::dm_addr_t data_addr,
	input  core_pkg::word_t    data_in,
	output core_pkg::word_t    data_out,
	input  logic [3:0]         con_write,    // Controller byte lanes
	input  core_pkg::dm_addr_t con_addr,
	input  core_pkg::word_t    con_in,
	output core_pkg::word_t    con_out
);
	import core_pkg::*;

	word_t mem [DMEM_WORDS];

	always_ff @(posedge clk) begin
		if (dm_write) begin
			mem[data_addr] <= data_in;
		end
		// Later assignment, controller wins on a shared word
		for (int i = 0; i < 4; i++) begin
			if (con_write[i]) begin
				mem[con_addr][8*i +: 8] <= con_in[8*i +: 8];
			end
		end
		con_out <= mem[con_addr];   // Registered, old contents
	end

	assign data_out = mem[data_addr];   // Async core read

endmodule

// ==== hdl/core.sv ====
`timescale 1ns/10ps

module core #(
	parameter int IMEM_WORDS = core_pkg::IMEM_WORDS,
	parameter int DMEM_WORDS = core_pkg::DMEM_WORDS
) (
	input  logic                CLK,
	input  logic                reset,
	input  logic                run,          // Low freezes the whole pipe
	input  logic                prog_write,   // Program load strobe
	input  core_pkg::im_addr_t  prog_addr,
	input  core_pkg::word_t     prog_in,
	input  logic [3:0]          con_write,    // Controller byte enables
	input  core_pkg::dm_addr_t  con_addr,
	input  core_pkg::word_t     con_in,
	output core_pkg::word_t     con_out
);
	import core_pkg::*;

	// IF
	pc_t       if_pc;
	word_t     if_inst;
	logic      if_en;          // PC and IF/ID advance
	logic      stall;          // Load-use hazard

	// ID
	word_t     id_inst;
	ctrl_t     id_ctrl;
	reg_addr_t id_rs1;
	reg_addr_t id_rs2;
	reg_addr_t id_rd;
	logic      id_uses_rs2;
	word_t     id_imm;
	word_t     id_rf_a;
	word_t     id_rf_b;
	word_t     id_src_a;       // Forwarded rs1 value
	word_t     id_src_b;       // Forwarded rs2 value

	// EXE
	ctrl_t     exe_ctrl;
	reg_addr_t exe_rd;
	word_t     exe_op_a;
	word_t     exe_op_b;
	word_t     exe_store;
	word_t     exe_alu;

	// MEM
	ctrl_t     mem_ctrl;
	reg_addr_t mem_rd;
	word_t     mem_alu;
	word_t     mem_store;
	word_t     mem_load;

	// WB
	ctrl_t     wb_ctrl;
	reg_addr_t wb_rd;
	word_t     wb_alu;
	word_t     wb_load;
	word_t     wb_data;

	forward_if fwd ();

	assign if_en = run && !stall;

	////////////////////
	// Fetch
	////////////////////
	always_ff @(posedge CLK) begin
		if (reset) begin
			if_pc   <= '0;
			id_inst <= NOP_INST;
		end else if (if_en) begin
			if_pc   <= if_pc + 12'd4;
			id_inst <= if_inst;    // IF/ID
		end
	end

	instmem #(.IMEM_WORDS(IMEM_WORDS)) instmem0 (
		.clk(CLK),
		.addr(if_pc),
		.inst(if_inst),
		.prog_write(prog_write),
		.prog_addr(prog_addr),
		.prog_in(prog_in)
	);

	////////////////////
	// Decode
	////////////////////
	decoder decoder0 (
		.inst(id_inst),
		.ctrl(id_ctrl),
		.rs1(id_rs1),
		.rs2(id_rs2),
		.rd(id_rd),
		.uses_rs2(id_uses_rs2),
		.imm(id_imm)
	);

	regfile regfile0 (
		.clk(CLK),
		.reset(reset),
		.wr_en(wb_ctrl.reg_write && run),
		.dest_addr(wb_rd),
		.wr_data(wb_data),
		.src1_addr(id_rs1),
		.src2_addr(id_rs2),
		.src1_out(id_rf_a),
		.src2_out(id_rf_b)
	);

	// Later stages fed back to decode
	assign fwd.exe_rd        = exe_rd;
	assign fwd.exe_reg_write = exe_ctrl.reg_write;
	assign fwd.exe_result    = exe_alu;
	assign fwd.exe_mem_read  = exe_ctrl.mem_read;
	assign fwd.mem_rd        = mem_rd;
	assign fwd.mem_reg_write = mem_ctrl.reg_write;
	assign fwd.mem_result    = mem_ctrl.mem_read ? mem_load : mem_alu;
	assign fwd.wb_rd         = wb_rd;
	assign fwd.wb_reg_write  = wb_ctrl.reg_write;
	assign fwd.wb_result     = wb_data;

	operand_forward forward0 (
		.fwd(fwd),
		.rs1(id_rs1),
		.rs2(id_rs2),
		.uses_rs2(id_uses_rs2),
		.rf_a(id_rf_a),
		.rf_b(id_rf_b),
		.op_a(id_src_a),
		.op_b(id_src_b),
		.stall(stall)
	);

	////////////////////
	// Pipeline registers
	////////////////////
	always_ff @(posedge CLK) begin
		if (reset) begin
			exe_ctrl <= CTRL_NOP;
			exe_rd   <= '0;
			mem_ctrl <= CTRL_NOP;
			mem_rd   <= '0;
			wb_ctrl  <= CTRL_NOP;
			wb_rd    <= '0;
		end else if (run) begin
			exe_ctrl <= stall ? CTRL_NOP : id_ctrl;   // Bubble on load-use
			exe_rd   <= id_rd;
			mem_ctrl <= exe_ctrl;
			mem_rd   <= exe_rd;
			wb_ctrl  <= mem_ctrl;
			wb_rd    <= mem_rd;
		end
	end

	// Datapath side, no reset
	always_ff @(posedge CLK) begin
		if (run) begin
			exe_op_a  <= id_src_a;
			exe_op_b  <= id_ctrl.use_imm ? id_imm : id_src_b;
			exe_store <= id_src_b;
			mem_alu   <= exe_alu;
			mem_store <= exe_store;
			wb_alu    <= mem_alu;
			wb_load   <= mem_load;
		end
	end

	////////////////////
	// Execute and memory
	////////////////////
	alu alu0 (
		.op_a(exe_op_a),
		.op_b(exe_op_b),
		.alu_op(exe_ctrl.alu_op),
		.res(exe_alu)
	);

	datamem #(.DMEM_WORDS(DMEM_WORDS)) datamem0 (
		.clk(CLK),
		.dm_write(mem_ctrl.mem_write && run),
		.data_addr(mem_alu[11:2]),     // Word address
		.data_in(mem_store),
		.data_out(mem_load),
		.con_write(con_write),
		.con_addr(con_addr),
		.con_in(con_in),
		.con_out(con_out)
	);

	// Write-back select
	assign wb_data = (wb_ctrl.wb_sel == WB_MEM) ? wb_load : wb_alu;

endmodule

// ==== tests/core_tb.sv ====
`timescale 1ns/10ps

module core_tb;
	import core_pkg::*;

	logic       clk = 1'b0;
	logic       reset;
	logic       run;
	logic       prog_write;
	im_addr_t   prog_addr;
	word_t      prog_in;
	logic [3:0] con_write;
	dm_addr_t   con_addr;
	word_t      con_in;
	word_t      con_out;

	// Stimulus queues, filled from the file
	im_addr_t   prog_addr_q[$];
	word_t      prog_data_q[$];
	dm_addr_t   data_addr_q[$];
	word_t      data_word_q[$];
	dm_addr_t   exp_addr_q[$];
	word_t      exp_word_q[$];

	int         stim_lines = 0;
	int         cycle_count = 0;
	int         cycle_limit = 0;   // Armed after the file is read

	core dut0 (
		.CLK(clk),
		.reset(reset),
		.run(run),
		.prog_write(prog_write),
		.prog_addr(prog_addr),
		.prog_in(prog_in),
		.con_write(con_write),
		.con_addr(con_addr),
		.con_in(con_in),
		.con_out(con_out)
	);

	always #2 clk = ~clk;   // 4 ns period

	////////////////////
	// Failure handling
	////////////////////
	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
			stop_with_failure("Data word mismatch");
		end
	endtask

	// Watchdog
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit != 0 && cycle_count > cycle_limit) begin
			stop_with_failure($sformatf("Timeout, no finish within %0d cycles", cycle_limit));
		end
	end

	////////////////////
	// Stimulus file
	////////////////////
	task automatic read_stimulus();
		int fd;
		int c;
		int n;
		logic [31:0] a;
		logic [31:0] d;
		fd = $fopen("tests/core_stimulus.txt", "r");
		if (fd == 0) begin
			stop_with_failure("Cannot open tests/core_stimulus.txt");
		end
		c = $fgetc(fd);
		while (c != -1) begin
			if (c == "#") begin
				while (c != "\n" && c != -1) begin   // Skip comment line
					c = $fgetc(fd);
				end
			end else if (c == "P" || c == "D" || c == "E") begin
				n = $fscanf(fd, "%h %h", a, d);
				if (n != 2) begin
					stop_with_failure("Malformed line in stimulus file");
				end
				stim_lines++;
				if (c == "P") begin
					prog_addr_q.push_back(im_addr_t'(a));
					prog_data_q.push_back(d);
				end else if (c == "D") begin
					data_addr_q.push_back(dm_addr_t'(a));
					data_word_q.push_back(d);
				end else begin
					exp_addr_q.push_back(dm_addr_t'(a));
					exp_word_q.push_back(d);
				end
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
	endtask

	// Controller port read, con_out valid one cycle after the address
	task automatic expect_con_word(input dm_addr_t addr, input word_t exp);
		@(negedge clk);
		con_addr = addr;
		@(negedge clk);
		compare_word($sformatf("con_out[%0d]", addr), con_out, exp);
	endtask

	////////////////////
	// Main sequence
	////////////////////
	initial begin
		reset      = 1'b1;
		run        = 1'b0;
		prog_write = 1'b0;
		prog_addr  = '0;
		prog_in    = '0;
		con_write  = 4'h0;
		con_addr   = '0;
		con_in     = '0;

		read_stimulus();
		if (prog_addr_q.size() == 0 || exp_addr_q.size() == 0) begin
			stop_with_failure("Stimulus file holds no program or no expected words");
		end
		cycle_limit = stim_lines * 4 + prog_addr_q.size() * 2 + 50;

		repeat (8) @(negedge clk);
		reset = 1'b0;

		foreach (prog_addr_q[i]) begin   // Program load, run still low
			@(negedge clk);
			prog_write = 1'b1;
			prog_addr  = prog_addr_q[i];
			prog_in    = prog_data_q[i];
		end
		@(negedge clk);
		prog_write = 1'b0;

		foreach (data_addr_q[i]) begin   // Data preloads, full words
			@(negedge clk);
			con_write = 4'hF;
			con_addr  = data_addr_q[i];
			con_in    = data_word_q[i];
		end
		@(negedge clk);
		con_write = 4'h0;

		// Preloads read back before the core runs
		foreach (data_addr_q[i]) begin
			expect_con_word(data_addr_q[i], data_word_q[i]);
		end

		@(negedge clk);
		run = 1'b1;
		repeat (prog_addr_q.size() + 8) @(negedge clk);
		run = 1'b0;

		foreach (exp_addr_q[i]) begin
			expect_con_word(exp_addr_q[i], exp_word_q[i]);
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== tests/core_stimulus.txt ====
# Columns: tag, hex address, hex word. P = program word at instruction word address,
# D = data preload at data word address, E = expected data word after the run
P 00 06400093
P 01 FF900113
P 02 123451B7
P 03 6781E213
P 04 FFA12293
P 05 01C15313
P 06 00402023
P 07 00502223
P 08 00602423
P 09 402083B3
P 0A 00112433
P 0B 02400513
P 0C 00A095B3
P 0D 00A15633
P 0E 001246B3
P 0F 00627733
P 10 0061E7B3
P 11 00702623
P 12 00802823
P 13 00B02A23
P 14 00C02C23
P 15 00D02E23
P 16 02E02023
P 17 02F02223
P 18 00500813
P 19 010808B3
P 1A 01088933
P 1B 010909B3
P 1C 01198A33
P 1D 03402423
P 1E 00100A93
P 1F 00200A93
P 20 015A8B33
P 21 03602623
P 22 19002B83
P 23 001B8C33
P 24 03802823
P 25 03700013
P 26 02002A23
# Load source and a word that SW of x0 must clear
D 064 CAFE0000
D 00D DEADBEEF
E 000 12345678
E 001 00000001
E 002 0000000F
E 003 0000006B
E 004 00000001
E 005 00000640
E 006 0FFFFFFF
E 007 1234561C
E 008 00000008
E 009 1234500F
E 00A 0000001E
E 00B 00000004
E 00C CAFE0064
E 00D 00000000
E 064 CAFE0000

// ==== all.f ====
hdl/core_pkg.sv
hdl/core_if.sv
hdl/instmem.sv
hdl/decoder.sv
hdl/regfile.sv
hdl/operand_forward.sv
hdl/alu.sv
hdl/datamem.sv
hdl/core.sv
tests/core_tb.sv
